//--- bridge.f
+incdir+sim
source/bridge_pkg.sv
source/sd_pkg.sv
source/dram_req_if.sv
source/sd_req_if.sv
source/dram_axi_port.sv
source/transfer_ctrl.sv
source/sd_spi_engine.sv
source/byte_serializer.sv
source/bridge_top.sv
sim/tb_bridge.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the bridge testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert --timescale 1ns/1ps --top-module tb_bridge -f bridge.f \
    || { echo "Build failed"; exit 1; }
./obj_dir/Vtb_bridge 2>&1 | tee sim.log
grep -qx "No errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- sim/tb_bus_models.svh
/*
 * Bus models that the testbench runs against the DUT
 * SD card in SPI mode on MOSI/MISO
 * DRAM slave on the AXI-style read and write channels
 */
`ifndef TB_BUS_MODELS_SVH
`define TB_BUS_MODELS_SVH

// ####################
// SD card
// ####################

// Command frame of start bits, index, 16 zero bits, block address, CRC7 and end bit
function automatic logic [47:0] cmd_frame(input sd_cmd_e cmd, input sd_addr_t addr);
    logic [39:0] body;
    body = {2'b01, cmd, 16'h0000, addr};
    return {body, crc7(body), 1'b1};
endfunction

// Waits for the start bit, then takes the frame MSB first
task automatic capture_cmd_frame(output logic [47:0] frame);
    int i;
    while (MOSI) step();
    frame = '0;
    for (i = 0; i < CMD_FRAME_BITS; i++) begin
        frame = {frame[46:0], MOSI};
        step();
    end
endtask

// Drives the top n bits on MISO, MSB first, then idles high
task automatic send_miso(input logic [87:0] bits, input int n);
    int i;
    for (i = 0; i < n; i++) begin
        MISO = bits[87 - i];
        step();
    end
    MISO = 1'b1;
endtask

// Card side of CMD17 with R1, start token, block and CRC16
task automatic sd_card_read(input sd_addr_t addr, input block_t blk);
    logic [47:0] frame;
    capture_cmd_frame(frame);
    check_block("MOSI CMD17 frame", block_t'(cmd_frame(CMD_READ_SINGLE, addr)),
                block_t'(frame));
    repeat (2) step();
    send_miso(88'h0, RESP_BITS);
    repeat (2) step();
    send_miso({DATA_TOKEN, blk, crc16(blk)}, 88);
endtask

// Card side of CMD24 with R1, then gap, token, block and CRC16 on MOSI
task automatic sd_card_write(input sd_addr_t addr, input block_t blk, input int busy_cycles);
    logic [47:0] frame;
    block_t      data;
    logic [15:0] crc;
    int          ones;
    int          i;
    capture_cmd_frame(frame);
    check_block("MOSI CMD24 frame", block_t'(cmd_frame(CMD_WRITE_SINGLE, addr)),
                block_t'(frame));
    repeat (2) step();
    send_miso(88'h0, RESP_BITS);
    // Gap plus the seven leading ones of 0xFE up to its final zero
    ones = 0;
    while (MOSI) begin
        ones++;
        step();
    end
    if (ones < GAP_BITS + 7) begin
        stop_on_error($sformatf("MOSI held only %0d high bits before the data token ended",
                                ones));
    end
    data = '0;
    crc  = '0;
    for (i = 0; i < 64; i++) begin
        step();
        data = {data[62:0], MOSI};
    end
    for (i = 0; i < DATA_CRC_BITS; i++) begin
        step();
        crc = {crc[14:0], MOSI};
    end
    check_block("MOSI data block", blk, data);
    check_block("MOSI data CRC16", block_t'(crc16(blk)), block_t'(crc));
    // Data response start, then busy held low
    step();
    MISO = 1'b0;
    repeat (busy_cycles) begin
        step();
        check_bit("out_valid", 1'b0, out_valid);
    end
    MISO = 1'b1;
endtask

// ####################
// DRAM slave
// ####################

task automatic dram_read_slave(input dram_addr_t addr, input block_t blk,
                               input int ar_wait, input int r_wait);
    while (!AR_VALID) step();
    check_addr("AR_ADDR", axi_addr_t'(addr), AR_ADDR);
    repeat (ar_wait) begin
        step();
        check_bit("AR_VALID", 1'b1, AR_VALID);
        check_addr("AR_ADDR", axi_addr_t'(addr), AR_ADDR);
    end
    AR_READY = 1'b1;
    step();
    AR_READY = 1'b0;
    check_bit("AR_VALID", 1'b0, AR_VALID);
    check_addr("AR_ADDR", '0, AR_ADDR);
    while (!R_READY) step();
    repeat (r_wait) step();
    R_VALID = 1'b1;
    R_DATA  = blk;
    step();
    R_VALID = 1'b0;
    R_DATA  = '0;
    check_bit("R_READY", 1'b0, R_READY);
endtask

task automatic dram_write_slave(input dram_addr_t addr, input block_t blk,
                                input int aw_wait, input int w_wait);
    while (!AW_VALID) step();
    check_addr("AW_ADDR", axi_addr_t'(addr), AW_ADDR);
    repeat (aw_wait) begin
        step();
        check_bit("AW_VALID", 1'b1, AW_VALID);
        check_addr("AW_ADDR", axi_addr_t'(addr), AW_ADDR);
    end
    AW_READY = 1'b1;
    step();
    AW_READY = 1'b0;
    check_bit("AW_VALID", 1'b0, AW_VALID);
    check_addr("AW_ADDR", '0, AW_ADDR);
    while (!W_VALID) step();
    check_block("W_DATA", blk, W_DATA);
    repeat (w_wait) begin
        step();
        check_bit("W_VALID", 1'b1, W_VALID);
        check_block("W_DATA", blk, W_DATA);
    end
    W_READY = 1'b1;
    step();
    W_READY = 1'b0;
    check_bit("W_VALID", 1'b0, W_VALID);
    check_block("W_DATA", '0, W_DATA);
    while (!B_READY) step();
    step();
    B_VALID = 1'b1;
    step();
    B_VALID = 1'b0;
    check_bit("B_READY", 1'b0, B_READY);
endtask

`endif

//--- sim/tb_bridge.sv
/*
 * Testbench for the DRAM to SD card bridge: clock, reset, watchdog,
 * compare tasks and directed transfers in both directions
 */
`timescale 1ns/1ps
`default_nettype none

module tb_bridge import bridge_pkg::*, sd_pkg::*; ();

    localparam int AXI_ADDR_W       = 32;
    localparam int CLK_HALF         = 2;
    localparam int DRIVE_DELAY      = 1;
    localparam int RANDOM_TRANSFERS = 6;
    localparam int NUM_TRANSFERS    = 4 + RANDOM_TRANSFERS;
    localparam int WATCHDOG_CYCLES  = NUM_TRANSFERS * 600;

    typedef logic [AXI_ADDR_W-1:0] axi_addr_t;

    logic       clk;
    logic       rst_n;
    logic       in_valid;
    logic       direction;
    dram_addr_t addr_dram;
    sd_addr_t   addr_sd;
    logic       out_valid;
    byte_t      out_data;
    logic       AR_VALID;
    axi_addr_t  AR_ADDR;
    logic       AR_READY;
    logic       R_VALID;
    block_t     R_DATA;
    logic       R_READY;
    logic       AW_VALID;
    axi_addr_t  AW_ADDR;
    logic       AW_READY;
    logic       W_VALID;
    block_t     W_DATA;
    logic       W_READY;
    logic       B_VALID;
    logic       B_READY;
    logic       MISO;
    logic       MOSI;
    integer     seed;

    bridge_top #(.AXI_ADDR_W(AXI_ADDR_W)) UUT (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_HALF) clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        stop_on_error($sformatf("Timeout: the transfers did not finish within %0d cycles",
                                WATCHDOG_CYCLES));
    end

    // ####################
    // Helpers and compare tasks
    // ####################

    // Inputs change and outputs are read just after the rising edge
    task automatic step();
        @(posedge clk);
        #(DRIVE_DELAY);
    endtask

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Errors found");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_byte(input string name, input byte_t exp, input byte_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("Mismatch at %0d ns: %s expected %h, got %h",
                                    $time, name, exp, act));
        end
    endtask

    task automatic check_block(input string name, input block_t exp, input block_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("Mismatch at %0d ns: %s expected %h, got %h",
                                    $time, name, exp, act));
        end
    endtask

    task automatic check_addr(input string name, input axi_addr_t exp, input axi_addr_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("Mismatch at %0d ns: %s expected %h, got %h",
                                    $time, name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_on_error($sformatf("Mismatch at %0d ns: %s expected %b, got %b",
                                    $time, name, exp, act));
        end
    endtask

    `include "tb_bus_models.svh"

    task automatic start_request(input xfer_dir_e dir, input dram_addr_t a_dram,
                                 input sd_addr_t a_sd);
        in_valid  = 1'b1;
        direction = dir;
        addr_dram = a_dram;
        addr_sd   = a_sd;
        step();
        in_valid  = 1'b0;
    endtask

    // Eight bytes MSB first, then out_valid drops
    task automatic verify_output_bytes(input block_t exp);
        int i;
        while (!out_valid) step();
        for (i = 0; i < BYTES_PER_BLOCK; i++) begin
            check_bit("out_valid", 1'b1, out_valid);
            check_byte("out_data", exp[63 - 8 * i -: 8], out_data);
            step();
        end
        check_bit("out_valid", 1'b0, out_valid);
        check_byte("out_data", 8'h00, out_data);
    endtask

    task automatic move_sd_to_dram(input dram_addr_t a_dram, input sd_addr_t a_sd,
                                   input block_t blk, input int wait_n);
        start_request(DIR_SD_TO_DRAM, a_dram, a_sd);
        sd_card_read(a_sd, blk);
        dram_write_slave(a_dram, blk, wait_n, wait_n);
        verify_output_bytes(blk);
    endtask

    task automatic move_dram_to_sd(input dram_addr_t a_dram, input sd_addr_t a_sd,
                                   input block_t blk, input int wait_n);
        start_request(DIR_DRAM_TO_SD, a_dram, a_sd);
        dram_read_slave(a_dram, blk, wait_n, 1);
        sd_card_write(a_sd, blk, 3 + wait_n);
        verify_output_bytes(blk);
    endtask

    // ####################
    // Directed tests
    // ####################

    task automatic after_reset_values();
        repeat (2) @(posedge clk);
        #(DRIVE_DELAY);
        rst_n = 1'b1;
        step();
        check_bit("AR_VALID", 1'b0, AR_VALID);
        check_bit("AW_VALID", 1'b0, AW_VALID);
        check_bit("W_VALID", 1'b0, W_VALID);
        check_bit("R_READY", 1'b0, R_READY);
        check_bit("B_READY", 1'b0, B_READY);
        check_bit("out_valid", 1'b0, out_valid);
        check_byte("out_data", 8'h00, out_data);
        check_addr("AR_ADDR", '0, AR_ADDR);
        check_addr("AW_ADDR", '0, AW_ADDR);
        check_block("W_DATA", '0, W_DATA);
        check_bit("MOSI", 1'b1, MOSI);
    endtask

    task automatic sd_to_dram_transfer();
        move_sd_to_dram(13'h1A5C, 16'h0042, 64'h0123_4567_89AB_CDEF, 0);
    endtask

    task automatic dram_to_sd_transfer();
        move_dram_to_sd(13'h0F0F, 16'hBEEF, 64'hFEDC_BA98_7654_3210, 0);
    endtask

    task automatic back_pressure_transfers();
        move_sd_to_dram(13'h1FFF, 16'h8001, 64'hA5A5_5A5A_C3C3_3C3C, 5);
        move_dram_to_sd(13'h0001, 16'h7FFE, 64'h0F1E_2D3C_4B5A_6978, 6);
    endtask

    task automatic random_transfers();
        dram_addr_t a_dram;
        sd_addr_t   a_sd;
        block_t     blk;
        int         wait_n;
        int         n;
        for (n = 0; n < RANDOM_TRANSFERS; n++) begin
            a_dram = dram_addr_t'($random(seed));
            a_sd   = sd_addr_t'($random(seed));
            blk    = {$random(seed), $random(seed)};
            wait_n = $random(seed) & 3;
            // Alternate so both directions are covered
            if (n % 2 == 0) begin
                move_sd_to_dram(a_dram, a_sd, blk, wait_n);
            end else begin
                move_dram_to_sd(a_dram, a_sd, blk, wait_n);
            end
            step();
        end
    endtask

    initial begin
        seed      = 80892;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        direction = 1'b0;
        addr_dram = '0;
        addr_sd   = '0;
        AR_READY  = 1'b0;
        R_VALID   = 1'b0;
        R_DATA    = '0;
        AW_READY  = 1'b0;
        W_READY   = 1'b0;
        B_VALID   = 1'b0;
        MISO      = 1'b1;
        after_reset_values();
        sd_to_dram_transfer();
        step();
        dram_to_sd_transfer();
        step();
        back_pressure_transfers();
        step();
        random_transfers();
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- source/bridge_top.sv
/*
 * Top level of the DRAM to SD card bridge:
 * controller, DRAM bus port, SD SPI engine and byte serializer
 */
`timescale 1ns/1ps
`default_nettype none

module bridge_top import bridge_pkg::*, sd_pkg::*; #(
    parameter int AXI_ADDR_W = 32
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    input  logic                  direction,
    input  dram_addr_t            addr_dram,
    input  sd_addr_t              addr_sd,
    output logic                  out_valid,
    output byte_t                 out_data,
    // AXI-style DRAM channels
    output logic                  AR_VALID,
    output logic [AXI_ADDR_W-1:0] AR_ADDR,
    input  logic                  AR_READY,
    input  logic                  R_VALID,
    input  block_t                R_DATA,
    output logic                  R_READY,
    output logic                  AW_VALID,
    output logic [AXI_ADDR_W-1:0] AW_ADDR,
    input  logic                  AW_READY,
    output logic                  W_VALID,
    output block_t                W_DATA,
    input  logic                  W_READY,
    input  logic                  B_VALID,
    output logic                  B_READY,
    // SD card in SPI mode
    input  logic                  MISO,
    output logic                  MOSI
);

    logic   ser_load;
    block_t ser_block;

    dram_req_if dram_bus ();
    sd_req_if   sd_bus ();

    transfer_ctrl u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .direction (xfer_dir_e'(direction)),
        .addr_dram (addr_dram),
        .addr_sd   (addr_sd),
        .dram      (dram_bus.ctrl),
        .sd        (sd_bus.ctrl),
        .load      (ser_load),
        .block     (ser_block)
    );

    dram_axi_port #(
        .AXI_ADDR_W (AXI_ADDR_W)
    ) u_dram_port (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (dram_bus.port),
        .AR_VALID (AR_VALID),
        .AR_ADDR  (AR_ADDR),
        .AR_READY (AR_READY),
        .R_VALID  (R_VALID),
        .R_DATA   (R_DATA),
        .R_READY  (R_READY),
        .AW_VALID (AW_VALID),
        .AW_ADDR  (AW_ADDR),
        .AW_READY (AW_READY),
        .W_VALID  (W_VALID),
        .W_DATA   (W_DATA),
        .W_READY  (W_READY),
        .B_VALID  (B_VALID),
        .B_READY  (B_READY)
    );

    sd_spi_engine u_sd_engine (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (sd_bus.engine),
        .MISO  (MISO),
        .MOSI  (MOSI)
    );

    byte_serializer u_serializer (
        .clk       (clk),
        .rst_n     (rst_n),
        .load      (ser_load),
        .block     (ser_block),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

`default_nettype wire

//--- source/byte_serializer.sv
/*
 * Output stage: emits a loaded 64-bit block as eight bytes,
 * most significant byte first, with out_valid high per byte
 */
`timescale 1ns/1ps
`default_nettype none

module byte_serializer import bridge_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   load,
    input  block_t block,
    output logic   out_valid,
    output byte_t  out_data
);

    logic [3:0] byte_cnt;
    block_t     rest_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_data  <= '0;
            byte_cnt  <= '0;
        end else if (load) begin
            out_valid <= 1'b1;
            out_data  <= block[63:56];
            byte_cnt  <= 4'd1;
        end else if (out_valid && byte_cnt == 4'(BYTES_PER_BLOCK)) begin
            out_valid <= 1'b0;
            out_data  <= '0;
            byte_cnt  <= '0;
        end else if (out_valid) begin
            out_data <= rest_q[63:56];
            byte_cnt <= byte_cnt + 4'd1;
        end
    end

    // Bytes still to go, top byte next
    always_ff @(posedge clk) begin
        if (load) begin
            rest_q <= block << 8;
        end else if (out_valid) begin
            rest_q <= rest_q << 8;
        end
    end

    idle_data_zero: assert property (@(posedge clk) disable iff (!rst_n)
        !out_valid |-> out_data == '0);

endmodule

`default_nettype wire

//--- source/sd_spi_engine.sv
/*
 * SD card SPI engine, one bit per clock:
 * command frame with CRC7, response wait, single block receive,
 * single block send with token and CRC16, busy wait
 */
`timescale 1ns/1ps
`default_nettype none

module sd_spi_engine import bridge_pkg::*, sd_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    sd_req_if.engine  req,
    input  logic      MISO,
    output logic      MOSI
);

    typedef enum logic [3:0] {
        S_IDLE,
        S_CMD,
        S_RESP_WAIT,
        S_RESP,
        S_TOKEN_WAIT,
        S_RX_DATA,
        S_RX_CRC,
        S_GAP,
        S_TX,
        S_DRESP_WAIT,
        S_BUSY
    } spi_state_e;

    localparam int DATA_BITS = $bits(block_t);
    // Token, data and CRC16 leave through one shift register
    localparam int TX_BITS   = $bits(DATA_TOKEN) + DATA_BITS + DATA_CRC_BITS;

    spi_state_e         state;
    logic [6:0]         bit_cnt;
    logic [TX_BITS-1:0] sh_q;
    block_t             rx_q;
    logic [39:0]        cmd_body;
    logic               is_write;
    logic               last_bit;

    // Start bits, index, 16 zero bits and the block address
    assign cmd_body  = {2'b01, req.cmd, 16'h0000, req.addr};
    assign is_write  = (req.cmd == CMD_WRITE_SINGLE);
    assign last_bit  = (bit_cnt == '0);
    assign req.rdata = rx_q;

    // ####################
    // Bit sequencing
    // ####################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            bit_cnt  <= '0;
            MOSI     <= 1'b1;
            req.done <= 1'b0;
        end else begin
            MOSI     <= 1'b1;
            req.done <= 1'b0;
            // Counted phases reload on entry
            bit_cnt  <= bit_cnt - 7'd1;
            case (state)
                S_IDLE: begin
                    if (req.start) begin
                        state   <= S_CMD;
                        bit_cnt <= 7'(CMD_FRAME_BITS - 1);
                    end
                end
                S_CMD: begin
                    MOSI <= sh_q[TX_BITS-1];
                    if (last_bit) begin
                        state <= S_RESP_WAIT;
                    end
                end
                S_RESP_WAIT: begin
                    // First low bit opens the response
                    if (!MISO) begin
                        state   <= S_RESP;
                        bit_cnt <= 7'(RESP_BITS - 2);
                    end
                end
                S_RESP: begin
                    if (last_bit && is_write) begin
                        state   <= S_GAP;
                        bit_cnt <= 7'(GAP_BITS - 1);
                    end else if (last_bit) begin
                        state <= S_TOKEN_WAIT;
                    end
                end
                S_TOKEN_WAIT: begin
                    // Trailing zero of the start token
                    if (!MISO) begin
                        state   <= S_RX_DATA;
                        bit_cnt <= 7'(DATA_BITS - 1);
                    end
                end
                S_RX_DATA: begin
                    if (last_bit) begin
                        state   <= S_RX_CRC;
                        bit_cnt <= 7'(DATA_CRC_BITS - 1);
                    end
                end
                S_RX_CRC: begin
                    if (last_bit) begin
                        state    <= S_IDLE;
                        req.done <= 1'b1;
                    end
                end
                S_GAP: begin
                    if (last_bit) begin
                        state   <= S_TX;
                        bit_cnt <= 7'(TX_BITS - 1);
                    end
                end
                S_TX: begin
                    MOSI <= sh_q[TX_BITS-1];
                    if (last_bit) begin
                        state <= S_DRESP_WAIT;
                    end
                end
                S_DRESP_WAIT: begin
                    if (!MISO) begin
                        state <= S_BUSY;
                    end
                end
                S_BUSY: begin
                    // Card holds MISO low while programming
                    if (MISO) begin
                        state    <= S_IDLE;
                        req.done <= 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Outgoing bits, MSB first
    always_ff @(posedge clk) begin
        if (state == S_IDLE && req.start) begin
            sh_q <= {cmd_body, crc7(cmd_body), 1'b1, {(TX_BITS - CMD_FRAME_BITS){1'b1}}};
        end else if (state == S_RESP && last_bit) begin
            sh_q <= {DATA_TOKEN, req.wdata, crc16(req.wdata)};
        end else if (state == S_CMD || state == S_TX) begin
            sh_q <= {sh_q[TX_BITS-2:0], 1'b1};
        end
    end

    // Incoming block, MSB first
    always_ff @(posedge clk) begin
        if (state == S_RX_DATA) begin
            rx_q <= {rx_q[DATA_BITS-2:0], MISO};
        end
    end

    start_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
        req.start |-> state == S_IDLE);

endmodule

`default_nettype wire

//--- source/transfer_ctrl.sv
/*
 * Transfer controller: captures a request, runs the DRAM and SD
 * phases in the order of the direction, hands the block across
 * and starts the byte output
 */
`timescale 1ns/1ps
`default_nettype none

module transfer_ctrl import bridge_pkg::*, sd_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       in_valid,
    input  xfer_dir_e  direction,
    input  dram_addr_t addr_dram,
    input  sd_addr_t   addr_sd,
    dram_req_if.ctrl   dram,
    sd_req_if.ctrl     sd,
    output logic       load,
    output block_t     block
);

    ctrl_state_e state;
    xfer_dir_e   dir_q;
    block_t      block_q;
    logic [3:0]  out_cnt;

    assign block      = block_q;
    assign dram.wdata = block_q;
    assign sd.wdata   = block_q;
    assign sd.cmd     = (dir_q == DIR_SD_TO_DRAM) ? CMD_READ_SINGLE : CMD_WRITE_SINGLE;

    // ####################
    // Phase FSM
    // ####################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= IDLE;
            dir_q         <= DIR_DRAM_TO_SD;
            out_cnt       <= '0;
            dram.rd_start <= 1'b0;
            dram.wr_start <= 1'b0;
            sd.start      <= 1'b0;
            load          <= 1'b0;
        end else begin
            dram.rd_start <= 1'b0;
            dram.wr_start <= 1'b0;
            sd.start      <= 1'b0;
            load          <= 1'b0;
            case (state)
                IDLE: begin
                    if (in_valid) begin
                        dir_q <= direction;
                        if (direction == DIR_SD_TO_DRAM) begin
                            state    <= SD_READ;
                            sd.start <= 1'b1;
                        end else begin
                            state         <= DRAM_READ;
                            dram.rd_start <= 1'b1;
                        end
                    end
                end
                DRAM_READ: begin
                    if (dram.done) begin
                        state    <= SD_WRITE;
                        sd.start <= 1'b1;
                    end
                end
                SD_READ: begin
                    if (sd.done) begin
                        state         <= DRAM_WRITE;
                        dram.wr_start <= 1'b1;
                    end
                end
                SD_WRITE, DRAM_WRITE: begin
                    if ((state == SD_WRITE && sd.done) || (state == DRAM_WRITE && dram.done)) begin
                        state <= OUTPUT;
                        load  <= 1'b1;
                    end
                end
                OUTPUT: begin
                    // Load cycle plus one per byte on out_data
                    out_cnt <= out_cnt + 4'd1;
                    if (out_cnt == 4'(BYTES_PER_BLOCK)) begin
                        state   <= IDLE;
                        out_cnt <= '0;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Request addresses and the block in flight
    always_ff @(posedge clk) begin
        if (state == IDLE && in_valid) begin
            dram.addr <= addr_dram;
            sd.addr   <= addr_sd;
        end
        if (state == DRAM_READ && dram.done) begin
            block_q <= dram.rdata;
        end else if (state == SD_READ && sd.done) begin
            block_q <= sd.rdata;
        end
    end

    in_valid_idle: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |-> state == IDLE);

endmodule

`default_nettype wire

//--- source/dram_axi_port.sv
/*
 * AXI-style master for the DRAM side, one 64-bit word per request:
 * read through AR/R, write through AW/W/B
 */
`timescale 1ns/1ps
`default_nettype none

module dram_axi_port import bridge_pkg::*; #(
    parameter int AXI_ADDR_W = 32
) (
    input  logic                  clk,
    input  logic                  rst_n,
    dram_req_if.port              req,
    output logic                  AR_VALID,
    output logic [AXI_ADDR_W-1:0] AR_ADDR,
    input  logic                  AR_READY,
    input  logic                  R_VALID,
    input  block_t                R_DATA,
    output logic                  R_READY,
    output logic                  AW_VALID,
    output logic [AXI_ADDR_W-1:0] AW_ADDR,
    input  logic                  AW_READY,
    output logic                  W_VALID,
    output block_t                W_DATA,
    input  logic                  W_READY,
    input  logic                  B_VALID,
    output logic                  B_READY
);

    typedef enum logic [2:0] {
        P_IDLE,
        P_AR,
        P_R,
        P_AW,
        P_W,
        P_B
    } phase_e;

    phase_e phase;

    // ####################
    // Channel sequencing
    // ####################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase    <= P_IDLE;
            AR_VALID <= 1'b0;
            AR_ADDR  <= '0;
            R_READY  <= 1'b0;
            AW_VALID <= 1'b0;
            AW_ADDR  <= '0;
            W_VALID  <= 1'b0;
            W_DATA   <= '0;
            B_READY  <= 1'b0;
            req.done <= 1'b0;
        end else begin
            req.done <= 1'b0;
            case (phase)
                P_IDLE: begin
                    if (req.rd_start) begin
                        phase    <= P_AR;
                        AR_VALID <= 1'b1;
                        AR_ADDR  <= AXI_ADDR_W'(req.addr);
                    end else if (req.wr_start) begin
                        phase    <= P_AW;
                        AW_VALID <= 1'b1;
                        AW_ADDR  <= AXI_ADDR_W'(req.addr);
                    end
                end
                P_AR: begin
                    if (AR_READY) begin
                        phase    <= P_R;
                        AR_VALID <= 1'b0;
                        AR_ADDR  <= '0;
                        R_READY  <= 1'b1;
                    end
                end
                P_R: begin
                    if (R_VALID) begin
                        phase    <= P_IDLE;
                        R_READY  <= 1'b0;
                        req.done <= 1'b1;
                    end
                end
                P_AW: begin
                    if (AW_READY) begin
                        phase    <= P_W;
                        AW_VALID <= 1'b0;
                        AW_ADDR  <= '0;
                        W_VALID  <= 1'b1;
                        W_DATA   <= req.wdata;
                    end
                end
                P_W: begin
                    if (W_READY) begin
                        phase   <= P_B;
                        W_VALID <= 1'b0;
                        W_DATA  <= '0;
                        B_READY <= 1'b1;
                    end
                end
                P_B: begin
                    if (B_VALID) begin
                        phase    <= P_IDLE;
                        B_READY  <= 1'b0;
                        req.done <= 1'b1;
                    end
                end
                default: phase <= P_IDLE;
            endcase
        end
    end

    // Read word, captured with the R handshake
    always_ff @(posedge clk) begin
        if (phase == P_R && R_VALID) begin
            req.rdata <= R_DATA;
        end
    end

    // Address valid is held with its address until the slave takes it
    ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        AR_VALID && !AR_READY |=> AR_VALID && $stable(AR_ADDR));
    aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        AW_VALID && !AW_READY |=> AW_VALID && $stable(AW_ADDR));

endmodule

`default_nettype wire

//--- source/sd_req_if.sv
/*
 * Request interface between the transfer controller and the
 * SD SPI engine: start pulse, command, block address, data, done
 */
`timescale 1ns/1ps
`default_nettype none

interface sd_req_if import bridge_pkg::*, sd_pkg::*; ();

    logic     start;
    sd_cmd_e  cmd;
    sd_addr_t addr;
    block_t   wdata;
    block_t   rdata;
    // One pulse per start
    logic     done;

    modport ctrl   (output start, cmd, addr, wdata, input rdata, done);
    modport engine (input start, cmd, addr, wdata, output rdata, done);

endinterface

`default_nettype wire

//--- source/dram_req_if.sv
/*
 * Request interface between the transfer controller and the
 * DRAM bus port: read and write start pulses, address, data, done
 */
`timescale 1ns/1ps
`default_nettype none

interface dram_req_if import bridge_pkg::*; ();

    logic       rd_start;
    logic       wr_start;
    dram_addr_t addr;
    block_t     wdata;
    block_t     rdata;
    // One pulse per start, rdata valid from here on
    logic       done;

    modport ctrl (output rd_start, wr_start, addr, wdata, input rdata, done);
    modport port (input rd_start, wr_start, addr, wdata, output rdata, done);

endinterface

`default_nettype wire

//--- source/sd_pkg.sv
/*
 * SD card SPI-mode protocol definitions:
 * block address type, command enum, frame and token lengths,
 * CRC7 for command frames and CRC16 for data blocks
 */
`default_nettype none

package sd_pkg;

    typedef logic [15:0] sd_addr_t;

    typedef enum logic [5:0] {
        CMD_READ_SINGLE  = 6'd17,
        CMD_WRITE_SINGLE = 6'd24
    } sd_cmd_e;

    // ####################
    // Frame lengths
    // ####################
    localparam int CMD_FRAME_BITS = 48;
    localparam int RESP_BITS      = 8;
    localparam int DATA_CRC_BITS  = 16;
    localparam int GAP_BITS       = 8;

    // Start token ahead of a data block
    localparam logic [7:0] DATA_TOKEN = 8'hFE;

    // ####################
    // CRC functions
    // ####################

    // x^7 + x^3 + 1 over start bits, index and argument, MSB first
    function automatic logic [6:0] crc7(input logic [39:0] data);
        logic [6:0] crc = '0;
        logic       fb;
        for (int i = 39; i >= 0; i--) begin
            fb  = data[i] ^ crc[6];
            crc = {crc[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
        end
        return crc;
    endfunction

    // CCITT polynomial 0x1021 over the data block, zero seed
    function automatic logic [15:0] crc16(input logic [63:0] data);
        logic [15:0] crc = '0;
        logic        fb;
        for (int i = 63; i >= 0; i--) begin
            fb  = data[i] ^ crc[15];
            crc = {crc[14:0], 1'b0} ^ (fb ? 16'h1021 : 16'h0000);
        end
        return crc;
    endfunction

endpackage

`default_nettype wire

//--- source/bridge_pkg.sv
/*
 * Transfer-level types shared by the bridge modules:
 * block and byte types, DRAM address, transfer direction,
 * controller phase enum and the block size in bytes
 */
`default_nettype none

package bridge_pkg;

    // One moved block and one output byte
    typedef logic [63:0] block_t;
    typedef logic [7:0]  byte_t;

    // DRAM word address as given on addr_dram
    typedef logic [12:0] dram_addr_t;

    typedef enum logic {
        DIR_DRAM_TO_SD = 1'b0,
        DIR_SD_TO_DRAM = 1'b1
    } xfer_dir_e;

    // Controller phases, two data phases per direction
    typedef enum logic [2:0] {
        IDLE,
        DRAM_READ,
        SD_WRITE,
        SD_READ,
        DRAM_WRITE,
        OUTPUT
    } ctrl_state_e;

    localparam int BYTES_PER_BLOCK = 8;

endpackage

`default_nettype wire
